//--- verif/mic_input.txt
// Columns: left word, right word, expected display (24-bit hex each)
// The display follows the left word; the right word must never show up
123456 fedcba 123456
800000 7fffff 800000
000000 ffffff 000000
ffffff 000000 ffffff
abcdef 012345 abcdef
5a5a5a a5a5a5 5a5a5a
fffff0 00000f fffff0
7fffff 800000 7fffff
0f1e2d 3c4b5a 0f1e2d
c0ffee 123abc c0ffee
000001 deadbe 000001
fedcba 654321 fedcba
13579b 2468ac 13579b
9abcde 111111 9abcde
876543 234567 876543
0a0b0c f0e0d0 0a0b0c

//--- sim.f
+incdir+common
common/board_pkg.sv
i2s/i2s_clock_gen.sv
i2s/i2s_rx_fsm.sv
src/seg_digit_scan.sv
src/board_top.sv
verif/board_checker.sv
verif/tb_board_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f sim.f \
    --top-module tb_board_top \
    -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_board_top
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

echo "Simulation completed"
exit 0

//--- verif/tb_board_top.sv
`default_nettype none

`include "board_defines.svh"

module tb_board_top;

    import board_pkg::*;

    localparam int SCAN_CYCLES = `NUM_DIGITS * `SCAN_TICKS;   // One pass over all digits
    localparam int FRAME_TIME  = 2 * `SLOT_BITS * 2 * `SCK_HALF * 10;
    localparam int MARGIN_TIME = 2000;

    logic                     clk;
    logic                     rst;
    logic                     sd;
    logic                     lr;
    logic                     sck;
    logic                     ws;
    logic [6:0]               hex0;
    logic [6:0]               hex1;
    logic [6:0]               hex2;
    logic [6:0]               hex3;
    logic [6:0]               hex4;
    logic [6:0]               hex5;
    logic [6:0]               hex6;
    logic [6:0]               hex7;
    logic [`NUM_DIGITS - 1:0] led;

    sample_t left_words[$];
    sample_t right_words[$];
    sample_t shown_words[$];      // Expected display per frame
    int      num_frames;
    bit      vectors_ready;
    int      cyc;                 // clk cycles since reset release
    integer  seed = 26;
    integer  filler;
    logic    mic_sck_last;
    logic    mic_ws_slot;
    int      mic_pos;             // sck period inside the slot
    int      mic_frame;           // -1 until the first left slot
    logic    mon_sck_last;
    logic    mon_ws_last;
    int      mon_half;
    int      mon_falls;
    bit      mon_toggled;

    board_top u_dut
    (
        .clk  ( clk  ),
        .rst  ( rst  ),
        .sd   ( sd   ),
        .lr   ( lr   ),
        .sck  ( sck  ),
        .ws   ( ws   ),
        .hex0 ( hex0 ),
        .hex1 ( hex1 ),
        .hex2 ( hex2 ),
        .hex3 ( hex3 ),
        .hex4 ( hex4 ),
        .hex5 ( hex5 ),
        .hex6 ( hex6 ),
        .hex7 ( hex7 ),
        .led  ( led  )
    );

    bind board_top board_checker u_checker
    (
        .clk   ( clk   ),
        .rst   ( rst   ),
        .digit ( digit ),
        .sck   ( sck   ),
        .ws    ( ws    )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //----------------------------------------
    // Reporting and compare tasks
    //----------------------------------------

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_hex(input string name, input logic [6:0] expected,
                             input logic [6:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_led(input logic [`NUM_DIGITS - 1:0] expected,
                             input logic [`NUM_DIGITS - 1:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL led: expected %h, got %h", expected, actual);
            abort_run();
        end
    endtask

    task automatic check_pin(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    //----------------------------------------
    // Display model
    //----------------------------------------

    // Seven-segment glyphs in abcdefgh order
    function automatic seg_t glyph_for(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 8'hfc;
            4'h1:    return 8'h60;
            4'h2:    return 8'hda;
            4'h3:    return 8'hf2;
            4'h4:    return 8'h66;
            4'h5:    return 8'hb6;
            4'h6:    return 8'hbe;
            4'h7:    return 8'he0;
            4'h8:    return 8'hfe;
            4'h9:    return 8'hf6;
            4'ha:    return 8'hee;
            4'hb:    return 8'h3e;
            4'hc:    return 8'h9c;
            4'hd:    return 8'h7a;
            4'he:    return 8'h9e;
            default: return 8'h8e;
        endcase
    endfunction

    function automatic seg_t digit_glyph(input sample_t value, input int index);
        seg_t g;
        g = 8'h00;                                    // Digits 6 and 7 stay blank
        if (index < `SHOWN_DIGITS)
            g = glyph_for(value[index * 4 +: 4]);
        if (index == `SHOWN_DIGITS - 1)
            g[0] = value[`SAMPLE_BITS - 1];           // Sign point
        return g;
    endfunction

    // Undo the reversed board order and the active-low segments
    function automatic seg_t seg_from_pins(input logic [6:0] pins, input logic dp);
        logic [7:0] hgfedcba;
        seg_t       s;
        hgfedcba = {dp, ~pins};
        for (int i = 0; i < 8; i++)
            s[7 - i] = hgfedcba[i];
        return s;
    endfunction

    function automatic logic [6:0] hex_pins(input int n);
        case (n)
            0:       return hex0;
            1:       return hex1;
            2:       return hex2;
            3:       return hex3;
            4:       return hex4;
            5:       return hex5;
            6:       return hex6;
            default: return hex7;
        endcase
    endfunction

    //----------------------------------------
    // Stimulus and sequencing
    //----------------------------------------

    task automatic read_vectors();
        int      fd;
        int      got;
        int      count;
        string   line;
        sample_t left_w;
        sample_t right_w;
        sample_t shown_w;
        fd = $fopen("verif/mic_input.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open verif/mic_input.txt");
            abort_run();
        end
        else
        begin
            while (!$feof(fd))
            begin
                line  = "";
                got   = $fgets(line, fd);
                count = $sscanf(line, "%h %h %h", left_w, right_w, shown_w);
                if (got > 0 && count == 3)            // Comment lines do not scan
                begin
                    left_words.push_back(left_w);
                    right_words.push_back(right_w);
                    shown_words.push_back(shown_w);
                end
            end
            $fclose(fd);
            num_frames = left_words.size();
        end
    endtask

    task automatic drive_mic_bit();
        sample_t word;
        if (mic_frame >= 0 && mic_frame < num_frames && mic_pos >= 1 &&
            mic_pos <= `SAMPLE_BITS)
        begin
            word = mic_ws_slot ? right_words[mic_frame] : left_words[mic_frame];
            sd   = word[`SAMPLE_BITS - mic_pos];     // MSB one period after ws
        end
        else
        begin
            filler = $random(seed);
            sd     = filler[0];
        end
    endtask

    task automatic check_reset_state();
        check_pin("sck", 1'b0, sck);
        check_pin("ws", 1'b0, ws);
        check_pin("lr", 1'b0, lr);
        check_led('0, led);
        for (int n = 0; n < `NUM_DIGITS; n++)
            check_hex($sformatf("hex%0d", n), 7'h7f, hex_pins(n));
    endtask

    // Compare every output over one full scan against the given value
    task automatic scan_display(input sample_t value);
        int                       active;
        seg_t                     glyph;
        logic [`NUM_DIGITS - 1:0] exp_led;
        for (int c = 0; c < SCAN_CYCLES; c++)
        begin
            @(negedge clk);
            active  = ((cyc - 1) / `SCAN_TICKS) % `NUM_DIGITS;
            glyph   = digit_glyph(value, active);
            exp_led = '0;
            exp_led[active] = glyph[0];
            for (int n = 0; n < `NUM_DIGITS; n++)
            begin
                if (n != active)
                    check_hex($sformatf("hex%0d", n), 7'h7f, hex_pins(n));
            end
            check_seg($sformatf("hex%0d", active), glyph,
                      seg_from_pins(hex_pins(active), led[active]));
            check_led(exp_led, led);
        end
    endtask

    task automatic wait_left_start();
        logic ws_prev;
        ws_prev = ws;
        @(negedge clk);
        while (!(ws_prev === 1'b1 && ws === 1'b0))
        begin
            ws_prev = ws;
            @(negedge clk);
        end
    endtask

    initial
    begin
        cyc = 0;
        forever
        begin
            @(posedge clk);
            if (!rst)
                cyc++;
        end
    end

    // Microphone model puts a new bit out on the falling clk after each sck fall
    initial
    begin
        sd           = 1'b0;
        mic_sck_last = 1'b0;
        mic_ws_slot  = 1'b0;
        mic_pos      = 0;
        mic_frame    = -1;
        forever
        begin
            @(negedge clk);
            if (mic_sck_last === 1'b1 && sck === 1'b0)
            begin
                if (ws !== mic_ws_slot)
                begin
                    mic_ws_slot = ws;
                    mic_pos     = 0;
                    if (ws === 1'b0)
                        mic_frame++;              // New frame with its left slot
                end
                else
                    mic_pos++;
                drive_mic_bit();
            end
            mic_sck_last = sck;
        end
    end

    // sck period and ws alignment
    initial
    begin
        mon_sck_last = 1'b0;
        mon_ws_last  = 1'b0;
        mon_half     = 0;
        mon_falls    = 0;
        mon_toggled  = 1'b0;
        forever
        begin
            @(negedge clk);
            mon_half++;
            if (sck !== mon_sck_last)
            begin
                if (mon_toggled && mon_half != `SCK_HALF)
                begin
                    $display("ERROR: sck held for %0d cycles instead of %0d", mon_half,
                             `SCK_HALF);
                    abort_run();
                end
                mon_toggled = 1'b1;
                mon_half    = 0;
                if (sck === 1'b0)
                    mon_falls++;
            end
            if (ws !== mon_ws_last)
            begin
                if (!(mon_sck_last === 1'b1 && sck === 1'b0) || mon_falls != `SLOT_BITS)
                begin
                    $display("ERROR: ws changed after %0d sck periods or off a falling sck",
                             mon_falls);
                    abort_run();
                end
                mon_falls = 0;
            end
            mon_sck_last = sck;
            mon_ws_last  = ws;
        end
    end

    initial
    begin
        int limit;
        wait (vectors_ready);
        limit = (num_frames + 2) * FRAME_TIME + MARGIN_TIME;
        #(limit);
        $display("ERROR: watchdog expired, the microphone frames never completed");
        abort_run();
    end

    initial
    begin
        rst = 1'b1;
        read_vectors();
        vectors_ready = 1'b1;
        repeat (2)
        begin
            @(negedge clk);
            check_reset_state();
        end
        rst = 1'b0;
        scan_display('0);                      // Nothing captured yet
        wait_left_start();                     // First left word goes out
        for (int i = 0; i < num_frames; i++)
        begin
            wait_left_start();                 // One frame later the word is shown
            scan_display(shown_words[i]);
        end
        if (num_frames > 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("ERROR: no frames were read from the data file");
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- verif/board_checker.sv
`default_nettype none

module board_checker
(
    input logic                  clk,
    input logic                  rst,
    input board_pkg::digit_sel_t digit,
    input logic                  sck,
    input logic                  ws
);

    // Never more than one HEX output enabled
    a_digit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(digit))
        else $error("digit select is not one-hot: %b", digit);

    // Word select switches only together with a falling sck
    a_ws_on_sck_fall: assert property
        (@(posedge clk) disable iff (rst) $changed(ws) |-> $fell(sck))
        else $error("ws changed away from a falling sck edge");

    // sck holds each level for more than one clk
    a_sck_hold: assert property
        (@(posedge clk) disable iff (rst) $changed(sck) |=> $stable(sck))
        else $error("sck toggled on two cycles in a row");

endmodule

`default_nettype wire

//--- src/board_top.sv
`default_nettype none

`include "board_defines.svh"

module board_top
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sd,
    output logic                       lr,
    output logic                       sck,
    output logic                       ws,
    output logic [6:0]                 hex0,
    output logic [6:0]                 hex1,
    output logic [6:0]                 hex2,
    output logic [6:0]                 hex3,
    output logic [6:0]                 hex4,
    output logic [6:0]                 hex5,
    output logic [6:0]                 hex6,
    output logic [6:0]                 hex7,
    output logic [`NUM_DIGITS - 1:0]   led
);

    import board_pkg::*;

    logic       sck_rise;
    sample_t    sample;
    logic       sample_valid;
    digit_sel_t digit;
    seg_t       abcdefgh;
    seg_t       hgfedcba;
    logic [6:0] hex [`NUM_DIGITS];

    assign lr = 1'b0;             // Microphone answers in the left slot

    //----------------------------------------
    // Microphone side
    //----------------------------------------

    i2s_clock_gen u_clock_gen
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .sck      ( sck      ),
        .ws       ( ws       ),
        .sck_rise ( sck_rise ),
        .sck_fall (          )
    );

    i2s_rx_fsm u_rx
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .ws           ( ws           ),
        .sd           ( sd           ),
        .sck_rise     ( sck_rise     ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    //----------------------------------------
    // Display side
    //----------------------------------------

    seg_digit_scan u_scan
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .digit        ( digit        ),
        .abcdefgh     ( abcdefgh     )
    );

    // Board segment order is hgfedcba
    always_comb
    begin
        for (int i = 0; i < $bits(seg_t); i++)
            hgfedcba[i] = abcdefgh[$bits(seg_t) - 1 - i];
    end

    for (genvar n = 0; n < `NUM_DIGITS; n++)
    begin : g_digit
        assign hex[n] = digit[n] ? ~hgfedcba[6:0] : '1;   // Active-low segments
        assign led[n] = digit[n] ?  hgfedcba[7]   : 1'b0; // Decimal point
    end

    assign hex0 = hex[0];
    assign hex1 = hex[1];
    assign hex2 = hex[2];
    assign hex3 = hex[3];
    assign hex4 = hex[4];
    assign hex5 = hex[5];
    assign hex6 = hex[6];
    assign hex7 = hex[7];

endmodule

`default_nettype wire

//--- src/seg_digit_scan.sv
`default_nettype none

`include "board_defines.svh"

module seg_digit_scan
(
    input  logic                  clk,
    input  logic                  rst,
    input  board_pkg::sample_t    sample,
    input  logic                  sample_valid,
    output board_pkg::digit_sel_t digit,
    output board_pkg::seg_t       abcdefgh
);

    import board_pkg::*;

    localparam int TICK_W = $clog2(`SCAN_TICKS);
    localparam int IDX_W  = $clog2(`NUM_DIGITS);

    sample_t             sample_q;   // Value on display
    logic [TICK_W - 1:0] tick_cnt;
    logic [IDX_W - 1:0]  idx;        // Binary index of the active digit
    seg_t                glyph;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sample_q <= '0;
        else if (sample_valid)
            sample_q <= sample;    // Newer sample simply overwrites
    end

    //----------------------------------------
    // Scan timer
    //----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit    <= '0;
            idx      <= '0;
            tick_cnt <= '0;
        end
        else if (digit == '0)
        begin
            // First cycle out of reset enables digit 0
            digit    <= digit_sel_t'(1);
            idx      <= '0;
            tick_cnt <= '0;
        end
        else if (tick_cnt == TICK_W'(`SCAN_TICKS - 1))
        begin
            tick_cnt <= '0;
            digit    <= {digit[`NUM_DIGITS - 2:0], digit[`NUM_DIGITS - 1]};
            if (idx == IDX_W'(`NUM_DIGITS - 1))
                idx <= '0;
            else
                idx <= idx + 1'b1;
        end
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    //----------------------------------------
    // Glyph decode
    //----------------------------------------

    always_comb
    begin
        if (idx < IDX_W'(`SHOWN_DIGITS))
            glyph = hex_to_seg(sample_q[idx * 4 +: 4]);
        else
            glyph = '0;            // Unused digits stay blank

        // Decimal point on the top digit marks a negative sample
        if (idx == IDX_W'(`SHOWN_DIGITS - 1))
            glyph[0] = sample_q[`SAMPLE_BITS - 1];
    end

    assign abcdefgh = glyph;

endmodule

`default_nettype wire

//--- i2s/i2s_rx_fsm.sv
`default_nettype none

`include "board_defines.svh"

module i2s_rx_fsm
(
    input  logic               clk,
    input  logic               rst,
    input  logic               ws,
    input  logic               sd,
    input  logic               sck_rise,
    output board_pkg::sample_t sample,
    output logic               sample_valid
);

    import board_pkg::*;

    localparam int CNT_W = $clog2(`SAMPLE_BITS);

    typedef enum logic [1:0]
    {
        wait_left,
        skip,
        shift,
        idle_right
    } state_t;

    state_t             state;
    logic               ws_q;
    logic [CNT_W - 1:0] bit_cnt;
    logic               last_bit;
    sample_t            shift_q;

    assign last_bit = sck_rise && (bit_cnt == CNT_W'(`SAMPLE_BITS - 1));

    //----------------------------------------
    // Control
    //----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state        <= wait_left;
            ws_q         <= 1'b0;
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            ws_q         <= ws;
            sample_valid <= 1'b0;

            case (state)
                wait_left:
                    if (ws_q && !ws)          // Left slot starts
                        state <= skip;
                skip:
                    if (sck_rise)             // One-bit I2S delay
                    begin
                        state   <= shift;
                        bit_cnt <= '0;
                    end
                shift:
                    if (last_bit)
                    begin
                        state        <= idle_right;
                        sample_valid <= 1'b1;
                    end
                    else if (sck_rise)
                        bit_cnt <= bit_cnt + 1'b1;
                default:
                    if (ws)                   // Right slot, nothing to take
                        state <= wait_left;
            endcase
        end
    end

    //----------------------------------------
    // Data path
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (state == shift && sck_rise)
            shift_q <= {shift_q[`SAMPLE_BITS - 2:0], sd}; // MSB first

        if (state == shift && last_bit)
            sample <= {shift_q[`SAMPLE_BITS - 2:0], sd};
    end

endmodule

`default_nettype wire

//--- i2s/i2s_clock_gen.sv
`default_nettype none

`include "board_defines.svh"

module i2s_clock_gen
(
    input  logic clk,
    input  logic rst,
    output logic sck,
    output logic ws,
    output logic sck_rise,
    output logic sck_fall
);

    localparam int HALF_W = $clog2(`SCK_HALF + 1);
    localparam int SLOT_W = $clog2(`SLOT_BITS);

    logic [HALF_W - 1:0] half_cnt;
    logic [SLOT_W - 1:0] bit_cnt;   // sck periods completed in the slot
    logic                half_end;

    assign half_end = (half_cnt == HALF_W'(`SCK_HALF - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            half_cnt <= '0;
            bit_cnt  <= '0;
            sck      <= 1'b0;
            ws       <= 1'b0;     // Left slot first
            sck_rise <= 1'b0;
            sck_fall <= 1'b0;
        end
        else
        begin
            sck_rise <= half_end & ~sck;
            sck_fall <= half_end &  sck;

            if (half_end)
            begin
                half_cnt <= '0;
                sck      <= ~sck;

                // Falling edge closes one sck period
                if (sck)
                begin
                    if (bit_cnt == SLOT_W'(`SLOT_BITS - 1))
                    begin
                        bit_cnt <= '0;
                        ws      <= ~ws;   // Switch channel with the fall
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
            end
            else
                half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- common/board_pkg.sv
`default_nettype none

`include "board_defines.svh"

package board_pkg;

    typedef logic [`SAMPLE_BITS - 1:0] sample_t;   // One microphone sample
    typedef logic [7:0]                seg_t;      // abcdefgh, h is the decimal point
    typedef logic [`NUM_DIGITS - 1:0]  digit_sel_t; // One-hot digit select

    // Standard seven-segment glyphs, decimal point off
    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110; // F
        endcase
    endfunction

endpackage

`default_nettype wire

//--- common/board_defines.svh
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

//----------------------------------------
// I2S timing
//----------------------------------------

// clk cycles per serial clock half period
`define SCK_HALF      2

// Serial clock periods per channel slot
`define SLOT_BITS     32

// Bits captured per microphone sample
`define SAMPLE_BITS   24

//----------------------------------------
// Display timing
//----------------------------------------

`define SCAN_TICKS    8   // clk cycles per digit, short for simulation
`define NUM_DIGITS    8   // HEX outputs on the board
`define SHOWN_DIGITS  6   // Digits that carry sample nibbles

`endif
